// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbNeoSystem
FILELIST = src.f
BUILD    = obj_dir
PASS     = === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(BUILD)

// File: common/cpuBusIf.sv
`timescale 1ns/1ps

interface cpuBusIf;
	logic [23:1] addr;
	logic [15:0] wrData;
	logic rw;      // High for read
	logic as;      // Level address strobe
	logic lds;     // Lower byte lane
	logic uds;     // Upper byte lane

	modport decoder (
		input addr,
		input wrData,
		input rw,
		input as,
		input lds,
		input uds
	);

	// Memories and address-written registers
	modport target (
		input addr,
		input wrData,
		input lds,
		input uds
	);

endinterface

// File: common/neoPkg.sv
package neoPkg;

	// Decoded 68000 bus zone
	typedef enum logic [2:0] {
		zoneNone,
		zoneWram,
		zoneCoin,
		zoneLatch,
		zonePal
	} zoneT;

	// System latch, one flag per address-only write
	typedef struct packed {
		logic palBank;          // Bit 7
		logic [4:0] reserved;   // Bits 6 to 2, stored only
		logic vecSel;           // Bit 1
		logic shadow;           // Bit 0
	} sysFlagsT;

	typedef struct packed {
		logic [6:0] r;
		logic [6:0] g;
		logic [6:0] b;
	} rgbT;

	// Palette RAM word
	typedef struct packed {
		logic dark;
		logic rLow;
		logic gLow;
		logic bLow;
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} palWordT;

endpackage

// File: common/neo_params.svh
`ifndef NEO_PARAMS_SVH
`define NEO_PARAMS_SVH

// Zone bases, compared on address bits 23 to 16
`define WRAM_BASE 24'h100000
`define COIN_BASE 24'h380000
`define SYSLATCH_BASE 24'h3A0000

// Palette zone is 0x400000 to 0x7FFFFF, mirrored
`define PAL_BASE 24'h400000

// Memory depths in 16-bit words
`define WRAM_WORDS 1024
`define PAL_WORDS 4096

// Coin counter pulse, in clock cycles
`define COIN_PULSE_CYCLES 8

`endif

// File: palette/colorOut.sv
`timescale 1ns/1ps

module colorOut import neoPkg::*; (
	input logic CLK_24M,
	input logic rst,
	input palWordT pixData,
	input logic pixDataValid,
	input logic shadow,
	output rgbT rgb,
	output logic rgbValid
);

	rgbT rgbNext;

	// Nibble, shared low bit, then inverted dark as LSB
	function automatic logic [6:0] level(input logic [3:0] nib, input logic low,
			input logic dark, input logic shade);
		logic [6:0] full;
		full = {nib, low, ~dark};
		return shade ? (full >> 1) : full;   // Shadow halves
	endfunction

	always_comb begin
		rgbNext.r = level(pixData.r, pixData.rLow, pixData.dark, shadow);
		rgbNext.g = level(pixData.g, pixData.gLow, pixData.dark, shadow);
		rgbNext.b = level(pixData.b, pixData.bLow, pixData.dark, shadow);
	end

	always_ff @(posedge CLK_24M) begin
		rgb <= rgbNext;
	end

	always_ff @(posedge CLK_24M) begin
		if (rst)
			rgbValid <= 1'b0;
		else
			rgbValid <= pixDataValid;
	end

endmodule

// File: palette/paletteRam.sv
`timescale 1ns/1ps
`include "neo_params.svh"

module paletteRam import neoPkg::*; (
	input logic CLK_24M,
	cpuBusIf.target bus,
	input logic we,
	input logic palBank,
	output palWordT rdData,
	input logic pixValid,
	input logic [11:0] palIndex,
	output palWordT pixData,
	output logic pixDataValid
);

	localparam int aw = $clog2(`PAL_WORDS);

	palWordT mem [2 * `PAL_WORDS];   // Two banks
	logic [aw:0] cpuIdx;
	logic [aw:0] pixIdx;

	assign cpuIdx = {palBank, bus.addr[aw:1]};
	assign pixIdx = {palBank, palIndex};

	// CPU side, byte lanes
	always_ff @(posedge CLK_24M) begin
		if (we && bus.uds)
			mem[cpuIdx][15:8] <= bus.wrData[15:8];
		if (we && bus.lds)
			mem[cpuIdx][7:0] <= bus.wrData[7:0];
		rdData <= mem[cpuIdx];
	end

	// Renderer lookup, one index per cycle
	always_ff @(posedge CLK_24M) begin
		pixData <= mem[pixIdx];
		pixDataValid <= pixValid;
	end

	// Renderer must present a real index with every strobe
	pixIndexKnown: assert property (@(posedge CLK_24M)
		pixValid |-> !$isunknown(palIndex));

endmodule

// File: rtl/coinCtrl.sv
`timescale 1ns/1ps
`include "neo_params.svh"

module coinCtrl (
	input logic CLK_24M,
	input logic rst,
	cpuBusIf.target bus,
	input logic we,
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2
);

	localparam int cntW = $clog2(`COIN_PULSE_CYCLES + 1);
	localparam logic [cntW-1:0] pulseLen = cntW'(`COIN_PULSE_CYCLES);

	logic [cntW-1:0] cnt1;
	logic [cntW-1:0] cnt2;

	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			cnt1 <= '0;
			cnt2 <= '0;
			lockout1 <= 1'b0;
			lockout2 <= 1'b0;
		end else begin
			if (cnt1 != '0)
				cnt1 <= cnt1 - 1'b1;
			if (cnt2 != '0)
				cnt2 <= cnt2 - 1'b1;
			// A later write wins over the countdown
			if (we) begin
				case (bus.addr[3:1])
					3'd0: cnt1 <= pulseLen;   // Retrigger restarts
					3'd1: cnt2 <= pulseLen;
					3'd2: lockout1 <= bus.addr[4];
					3'd3: lockout2 <= bus.addr[4];
					default: ;
				endcase
			end
		end
	end

	assign counter1 = |cnt1;
	assign counter2 = |cnt2;

	// Coin writes need a defined register index and level
	coinWriteKnown: assert property (@(posedge CLK_24M) disable iff (rst)
		we |-> !$isunknown(bus.addr[4:1]));

endmodule

// File: rtl/cpuDecoder.sv
`timescale 1ns/1ps
`include "neo_params.svh"

module cpuDecoder import neoPkg::*; (
	input logic CLK_24M,
	input logic rst,
	cpuBusIf.decoder bus,
	output logic wramWe,
	output logic palWe,
	output logic latchWe,
	output logic coinWe,
	input palWordT wramRdData,
	input palWordT palRdData,
	output logic [15:0] rdData,
	output logic dtack
);

	localparam logic [23:0] wramBase = `WRAM_BASE;
	localparam logic [23:0] coinBase = `COIN_BASE;
	localparam logic [23:0] latchBase = `SYSLATCH_BASE;
	localparam logic [23:0] palBase = `PAL_BASE;

	zoneT zone;
	zoneT zoneQ;     // Zone of the cycle being acknowledged
	logic asPrev;
	logic rwQ;
	logic start;     // First cycle of as high

	always_comb begin
		zone = zoneNone;
		if (bus.addr[23:22] == palBase[23:22])
			zone = zonePal;  // Whole 4 MB window
		else if (bus.addr[23:16] == wramBase[23:16])
			zone = zoneWram;
		else if (bus.addr[23:16] == coinBase[23:16])
			zone = zoneCoin;
		else if (bus.addr[23:16] == latchBase[23:16])
			zone = zoneLatch;
	end

	assign start = bus.as & ~asPrev;

	// Write strobes land on the edge where dtack rises
	assign wramWe = start & ~bus.rw & (zone == zoneWram);
	assign palWe = start & ~bus.rw & (zone == zonePal);
	assign latchWe = start & ~bus.rw & (zone == zoneLatch);
	assign coinWe = start & ~bus.rw & (zone == zoneCoin);

	always_ff @(posedge CLK_24M) begin
		if (rst) begin
			asPrev <= 1'b0;
			dtack <= 1'b0;
			zoneQ <= zoneNone;
			rwQ <= 1'b0;
		end else begin
			asPrev <= bus.as;
			dtack <= start;     // Single cycle, any zone
			if (start) begin
				zoneQ <= zone;
				rwQ <= bus.rw;
			end
		end
	end

	// RAM outputs are already registered on the start edge
	always_comb begin
		rdData = '0;
		if (dtack && rwQ) begin
			case (zoneQ)
				zoneWram: rdData = wramRdData;
				zonePal: rdData = palRdData;
				default: rdData = '0;   // Coin, latch, unmapped
			endcase
		end
	end

	// The master must keep as up until it has seen dtack
	dtackWithinAs: assert property (@(posedge CLK_24M) disable iff (rst)
		dtack |-> bus.as);

endmodule

// File: rtl/neoSystem.sv
`timescale 1ns/1ps

module neoSystem import neoPkg::*; (
	input logic CLK_24M,
	input logic rst,
	input logic [23:1] cpuAddr,
	input logic [15:0] cpuWrData,
	input logic cpuRw,
	input logic cpuAs,
	input logic cpuLds,
	input logic cpuUds,
	output logic [15:0] cpuRdData,
	output logic cpuDtack,
	input logic pixValid,
	input logic [11:0] palIndex,
	output logic [6:0] videoR,
	output logic [6:0] videoG,
	output logic [6:0] videoB,
	output logic rgbValid,
	output logic vecSel,
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2
);

	logic wramWe;
	logic palWe;
	logic latchWe;
	logic coinWe;
	palWordT wramRdData;
	palWordT palRdData;
	palWordT pixData;
	logic pixDataValid;
	sysFlagsT flags;
	rgbT rgb;

	cpuBusIf bus ();

	assign bus.addr = cpuAddr;
	assign bus.wrData = cpuWrData;
	assign bus.rw = cpuRw;
	assign bus.as = cpuAs;
	assign bus.lds = cpuLds;
	assign bus.uds = cpuUds;

	cpuDecoder decoder (.CLK_24M(CLK_24M), .rst(rst), .bus(bus.decoder),
		.wramWe(wramWe), .palWe(palWe), .latchWe(latchWe), .coinWe(coinWe),
		.wramRdData(wramRdData), .palRdData(palRdData),
		.rdData(cpuRdData), .dtack(cpuDtack));

	sysLatch latch (.CLK_24M(CLK_24M), .rst(rst), .bus(bus.target),
		.we(latchWe), .flags(flags));

	coinCtrl coin (.CLK_24M(CLK_24M), .rst(rst), .bus(bus.target), .we(coinWe),
		.counter1(counter1), .counter2(counter2),
		.lockout1(lockout1), .lockout2(lockout2));

	workRam wram (.CLK_24M(CLK_24M), .bus(bus.target), .we(wramWe),
		.rdData(wramRdData));

	paletteRam palRam (.CLK_24M(CLK_24M), .bus(bus.target), .we(palWe),
		.palBank(flags.palBank), .rdData(palRdData),
		.pixValid(pixValid), .palIndex(palIndex),
		.pixData(pixData), .pixDataValid(pixDataValid));

	colorOut colOut (.CLK_24M(CLK_24M), .rst(rst), .pixData(pixData),
		.pixDataValid(pixDataValid), .shadow(flags.shadow),
		.rgb(rgb), .rgbValid(rgbValid));

	assign vecSel = flags.vecSel;
	assign videoR = rgb.r;
	assign videoG = rgb.g;
	assign videoB = rgb.b;

endmodule

// File: rtl/sysLatch.sv
`timescale 1ns/1ps

module sysLatch import neoPkg::*; (
	input logic CLK_24M,
	input logic rst,
	cpuBusIf.target bus,
	input logic we,
	output sysFlagsT flags
);

	logic [2:0] sel;
	logic value;

	// Flag number from A3..A1, new level from A4
	assign sel = bus.addr[3:1];
	assign value = bus.addr[4];

	always_ff @(posedge CLK_24M) begin
		if (rst)
			flags <= '0;
		else if (we)
			flags[sel] <= value;   // Data bus not used
	end

endmodule

// File: rtl/workRam.sv
`timescale 1ns/1ps
`include "neo_params.svh"

module workRam import neoPkg::*; (
	input logic CLK_24M,
	cpuBusIf.target bus,
	input logic we,
	output palWordT rdData
);

	localparam int aw = $clog2(`WRAM_WORDS);

	logic [15:0] mem [`WRAM_WORDS];
	logic [aw-1:0] idx;

	// Upper address bits ignored, so the RAM wraps
	assign idx = bus.addr[aw:1];

	always_ff @(posedge CLK_24M) begin
		if (we && bus.uds)
			mem[idx][15:8] <= bus.wrData[15:8];
		if (we && bus.lds)
			mem[idx][7:0] <= bus.wrData[7:0];
	end

	// Read every cycle, decoder picks it up with dtack
	always_ff @(posedge CLK_24M) begin
		rdData <= palWordT'(mem[idx]);
	end

endmodule

// File: src.f
+incdir+common
common/neoPkg.sv
common/cpuBusIf.sv
rtl/cpuDecoder.sv
rtl/sysLatch.sv
rtl/coinCtrl.sv
rtl/workRam.sv
palette/paletteRam.sv
palette/colorOut.sv
rtl/neoSystem.sv
tests/tbNeoSystem.sv

// File: tests/tbNeoSystem.sv
`timescale 1ns/1ps
`include "neo_params.svh"

module tbNeoSystem import neoPkg::*; ();

	localparam int nWram = 64;
	localparam int nPix = 300;
	localparam int nShadePix = 200;
	localparam int pulse = `COIN_PULSE_CYCLES;
	localparam int totalOps = 3 * nWram + 2 * `PAL_WORDS + 2 * nPix + 4 * nShadePix + 300;
	localparam int timeoutCycles = totalOps * 20 + 1000;
	localparam logic [23:0] zeroAddr [6] = '{24'h000000, 24'h200000, `COIN_BASE + 24'h2,
		`SYSLATCH_BASE, 24'h800000, 24'hF00000};

	logic CLK_24M;
	logic rst;
	logic [23:1] cpuAddr;
	logic [15:0] cpuWrData;
	logic cpuRw;
	logic cpuAs;
	logic cpuLds;
	logic cpuUds;
	logic [15:0] cpuRdData;
	logic cpuDtack;
	logic pixValid;
	logic [11:0] palIndex;
	logic [6:0] videoR;
	logic [6:0] videoG;
	logic [6:0] videoB;
	logic rgbValid;
	logic vecSel;
	logic counter1;
	logic counter2;
	logic lockout1;
	logic lockout2;

	logic [15:0] wramModel [`WRAM_WORDS];
	palWordT palModel [2 * `PAL_WORDS];
	logic [7:0] flagModel;
	int wramUsed[$];
	rgbT expQ[$];
	int stampQ[$];    // Negedge on which each pixel result is due
	int errors = 0;
	int accessCount = 0;
	int dtackCount = 0;
	int pixChecked = 0;
	int negCount = 0;
	logic [3:0] coinSnap;   // Coin outputs seen together with dtack
	int el1 = 1000;         // Cycles since each counter pulse started
	int el2 = 1000;
	logic lo1 = 1'b0;
	logic lo2 = 1'b0;

	neoSystem dut_i (.*);

	initial begin
		CLK_24M = 1'b0;
		forever #20 CLK_24M = ~CLK_24M;
	end

	// Expected 7-bit level of one colour component
	function automatic logic [6:0] chanRef(input logic [3:0] nib, input logic low,
			input logic dark, input logic shade);
		int v;
		v = nib * 4 + low * 2 + (dark ? 0 : 1);
		if (shade)
			v = v / 2;
		return 7'(v);
	endfunction

	function automatic rgbT colorRef(input palWordT w, input logic shade);
		rgbT c;
		c.r = chanRef(w.r, w.rLow, w.dark, shade);
		c.g = chanRef(w.g, w.gLow, w.dark, shade);
		c.b = chanRef(w.b, w.bLow, w.dark, shade);
		return c;
	endfunction

	// {counter1, counter2, lockout1, lockout2}
	function automatic logic [3:0] coinRef(input int e1, input int e2, input logic l1,
			input logic l2);
		return {e1 < pulse, e2 < pulse, l1, l2};
	endfunction

	task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkRgb(input rgbT got, input rgbT exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: rgb %h/%h/%h, expected %h/%h/%h", $time,
				got.r, got.g, got.b, exp.r, exp.g, exp.b);
		end
	endtask

	task automatic checkCoin(input string what, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// One 68000 access with as held until dtack
	task automatic busCycle(input logic [23:0] a, input logic read, input logic [15:0] d,
			input logic u, input logic l, output logic [15:0] rd);
		int waited;
		logic seen;
		@(posedge CLK_24M);
		cpuAddr <= a[23:1];
		cpuRw <= read;
		cpuWrData <= d;
		cpuUds <= u;
		cpuLds <= l;
		cpuAs <= 1'b1;
		accessCount++;
		seen = 1'b0;
		waited = 0;
		rd = '0;
		while (!seen && waited < 16) begin
			@(negedge CLK_24M);
			waited++;
			if (cpuDtack) begin
				seen = 1'b1;
				rd = cpuRdData;
				coinSnap = {counter1, counter2, lockout1, lockout2};
			end
		end
		if (!seen) begin
			errors++;
			$display("no DTACK within 16 cycles for access to %h", a);
		end
		@(posedge CLK_24M);
		cpuAs <= 1'b0;
		cpuUds <= 1'b0;
		cpuLds <= 1'b0;
	endtask

	task automatic busWrite(input logic [23:0] a, input logic [15:0] d, input logic u,
			input logic l);
		logic [15:0] unused;
		busCycle(a, 1'b0, d, u, l, unused);
	endtask

	task automatic busRead(input logic [23:0] a, output logic [15:0] rd);
		busCycle(a, 1'b1, 16'($urandom), 1'b1, 1'b1, rd);
	endtask

	// Address-only write with random data and strobes
	task automatic setFlag(input int n, input logic v);
		busWrite(`SYSLATCH_BASE | (24'(v) << 4) | (24'(n) << 1), 16'($urandom),
			1'($urandom), 1'($urandom));
		flagModel[n] = v;
	endtask

	task automatic coinWrite(input int idx, input logic a4);
		busWrite(`COIN_BASE | (24'(a4) << 4) | (24'(idx) << 1), 16'($urandom), 1'b1, 1'b1);
		case (idx)
			0: el1 = 0;
			1: el2 = 0;
			2: lo1 = a4;
			3: lo2 = a4;
			default: ;
		endcase
		checkCoin("coin state with dtack", coinSnap, coinRef(el1, el2, lo1, lo2));
	endtask

	task automatic watchCoin(input int n);
		repeat (n) begin
			@(negedge CLK_24M);
			el1++;
			el2++;
			checkCoin("coin state", {counter1, counter2, lockout1, lockout2},
				coinRef(el1, el2, lo1, lo2));
		end
	endtask

	task automatic streamPixels(input int n, input logic [11:0] mask);
		logic [11:0] idx;
		int waited;
		repeat (n) begin
			@(posedge CLK_24M);
			idx = 12'($urandom) & mask;
			pixValid <= 1'b1;
			palIndex <= idx;
			expQ.push_back(colorRef(palModel[{flagModel[7], idx}], flagModel[0]));
			stampQ.push_back(negCount + 3);
		end
		@(posedge CLK_24M);
		pixValid <= 1'b0;
		waited = 0;
		while (expQ.size() > 0 && waited < 10) begin
			@(posedge CLK_24M);
			waited++;
		end
		if (expQ.size() > 0) begin
			errors++;
			$display("%0d pixel results never arrived", expQ.size());
			expQ.delete();
			stampQ.delete();
		end
	endtask

	// Checks pixel results and counts dtack pulses on the falling edge
	always @(negedge CLK_24M) begin
		rgbT got;
		int due;
		negCount++;
		if (cpuDtack)
			dtackCount++;
		if (rgbValid) begin
			got = {videoR, videoG, videoB};
			if (expQ.size() == 0) begin
				errors++;
				$display("rgbValid raised at %0t with no pixel outstanding", $time);
			end else begin
				due = stampQ.pop_front();
				if (due != negCount) begin
					errors++;
					$display("pixel result at %0t came %0d cycles off", $time, negCount - due);
				end
				checkRgb(got, expQ.pop_front());
				pixChecked++;
			end
		end
	end

	initial begin
		#(timeoutCycles * 40);
		$display("watchdog expired after %0d cycles, testbench did not finish", timeoutCycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [15:0] d;
		logic [15:0] rd;
		int i;
		int k;
		void'($urandom(32'hd60e_45f1));
		rst = 1'b1;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuRw = 1'b1;
		cpuAs = 1'b0;
		cpuLds = 1'b0;
		cpuUds = 1'b0;
		pixValid = 1'b0;
		palIndex = '0;
		flagModel = '0;
		repeat (10) @(posedge CLK_24M);
		rst <= 1'b0;

		// Work RAM words written partly through higher mirrors
		repeat (nWram) begin
			i = $urandom % `WRAM_WORDS;
			k = $urandom % 32;
			d = 16'($urandom);
			busWrite(`WRAM_BASE + 24'((i + k * `WRAM_WORDS) * 2), d, 1'b1, 1'b1);
			wramModel[i] = d;
			wramUsed.push_back(i);
		end
		repeat (nWram) begin
			i = wramUsed[$urandom % wramUsed.size()];
			k = $urandom % 2;
			d = 16'($urandom);
			busWrite(`WRAM_BASE + 24'(i * 2), d, k[0], ~k[0]);
			if (k[0])
				wramModel[i][15:8] = d[15:8];
			else
				wramModel[i][7:0] = d[7:0];
		end
		foreach (wramUsed[j]) begin
			busRead(`WRAM_BASE + 24'(wramUsed[j] * 2), rd);
			checkWord("work RAM", rd, wramModel[wramUsed[j]]);
		end
		foreach (zeroAddr[j]) begin
			busRead(zeroAddr[j], rd);
			checkWord("zero zone", rd, 16'h0000);
		end

		// Both palette banks selected by flag 7
		for (int b = 0; b < 2; b++) begin
			setFlag(7, 1'(b));
			for (int n = 0; n < `PAL_WORDS; n++) begin
				d = 16'($urandom);
				busWrite(`PAL_BASE + 24'(n * 2), d, 1'b1, 1'b1);
				palModel[b * `PAL_WORDS + n] = d;
			end
		end
		repeat (32) begin
			i = $urandom % `PAL_WORDS;
			busRead(24'h600000 + 24'(i * 2), rd);
			checkWord("palette", rd, palModel[{flagModel[7], 12'(i)}]);
		end
		streamPixels(nPix, 12'hfff);
		setFlag(7, 1'b0);
		streamPixels(nPix, 12'hfff);

		// Index 0 dark, index 1 bright
		busWrite(`PAL_BASE, 16'h8A5F, 1'b1, 1'b1);
		palModel[0] = 16'h8A5F;
		busWrite(`PAL_BASE + 24'h2, 16'h7A5F, 1'b1, 1'b1);
		palModel[1] = 16'h7A5F;
		setFlag(0, 1'b1);
		streamPixels(nShadePix, 12'h001);
		streamPixels(nShadePix, 12'hfff);
		setFlag(0, 1'b0);
		streamPixels(nShadePix, 12'h001);
		streamPixels(nShadePix, 12'hfff);

		// Coin pulses, retrigger and lockouts
		coinWrite(0, 1'b0);
		watchCoin(pulse + 2);
		coinWrite(1, 1'b1);
		watchCoin(pulse + 2);
		coinWrite(0, 1'b0);
		watchCoin(3);
		coinWrite(0, 1'b0);
		watchCoin(pulse + 2);
		coinWrite(2, 1'b1);
		coinWrite(3, 1'b1);
		coinWrite(5, 1'b1);
		coinWrite(2, 1'b0);
		watchCoin(2);

		// Vector select then reset with flags set
		setFlag(1, 1'b1);
		@(negedge CLK_24M);
		checkFlag("vecSel", vecSel, flagModel[1]);
		setFlag(1, 1'b0);
		@(negedge CLK_24M);
		checkFlag("vecSel", vecSel, flagModel[1]);
		setFlag(1, 1'b1);
		setFlag(0, 1'b1);
		setFlag(7, 1'b1);
		@(posedge CLK_24M);
		rst <= 1'b1;
		repeat (10) @(posedge CLK_24M);
		rst <= 1'b0;
		flagModel = '0;
		lo1 = 1'b0;
		lo2 = 1'b0;
		@(negedge CLK_24M);
		checkFlag("vecSel after reset", vecSel, 1'b0);
		checkCoin("coin after reset", {counter1, counter2, lockout1, lockout2},
			coinRef(el1, el2, lo1, lo2));
		streamPixels(64, 12'hfff);

		if (dtackCount != accessCount) begin
			errors++;
			$display("%0d bus accesses gave %0d DTACK pulses", accessCount, dtackCount);
		end
		$display("errors %0d, bus accesses %0d, pixels checked %0d", errors, accessCount,
			pixChecked);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
